// File: hw/ch3_arbiter.sv
`timescale 1ns/1ps

`include "m92_defs.svh"

module ch3_arbiter (
    input  logic                  clk_sys,
    input  logic                  arst_n,
    input  logic                  ioctl_download,
    input  m92_pkg::ioctl_index_t ioctl_index,
    sdram_ch_if.server            rom,
    input  m92_pkg::sdr_addr_t    cpu_addr,
    input  m92_pkg::sdr_word_t    cpu_din,
    input  m92_pkg::byte_sel_t    cpu_wr_sel,
    input  logic                  cpu_req,
    output logic                  cpu_rdy,
    output m92_pkg::sdr_word_t    cpu_dout,
    output m92_pkg::sdr_addr_t    sdr_ch3_addr,
    output m92_pkg::sdr_word_t    sdr_ch3_din,
    output m92_pkg::byte_sel_t    sdr_ch3_be,
    output logic                  sdr_ch3_rnw,
    output logic                  sdr_ch3_req,
    input  logic                  sdr_ch3_rdy,
    input  m92_pkg::sdr_word_t    sdr_ch3_dout
);
    import m92_pkg::*;

    ch3_owner_t owner;
    logic       rom_active;
    logic       owner_idle;
    logic       rom_own;

    assign rom_active = ioctl_download && (ioctl_index == `M92_ROM_INDEX);
    assign rom_own    = (owner == OWN_ROM);
    // Switch only between transactions of the current owner
    assign owner_idle = rom_own ? !rom.req : !cpu_req;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            owner <= OWN_CPU;
        end else if (owner_idle) begin
            owner <= rom_active ? OWN_ROM : OWN_CPU;
        end
    end

    // Field routing from the owner
    assign sdr_ch3_addr = rom_own ? rom.addr : cpu_addr;
    assign sdr_ch3_din  = rom_own ? rom.din  : cpu_din;
    assign sdr_ch3_be   = rom_own ? rom.be   : cpu_wr_sel;
    // CPU read when no byte lane is written
    assign sdr_ch3_rnw  = rom_own ? rom.rnw  : ~(|cpu_wr_sel);
    assign sdr_ch3_req  = rom_own ? rom.req  : cpu_req;

    // Completion goes back to the owner only
    assign rom.rdy  = rom_own && sdr_ch3_rdy;
    assign rom.dout = rom_own ? sdr_ch3_dout : '0;
    assign cpu_rdy  = !rom_own && sdr_ch3_rdy;
    assign cpu_dout = rom_own ? '0 : sdr_ch3_dout;

endmodule

// File: hw/dip_switch_bank.sv
`timescale 1ns/1ps

`include "m92_defs.svh"

module dip_switch_bank (
    input  logic                  clk_sys,
    input  logic                  arst_n,
    input  logic                  ioctl_wr,
    input  m92_pkg::ioctl_index_t ioctl_index,
    input  m92_pkg::sdr_addr_t    ioctl_addr,
    input  m92_pkg::ioctl_byte_t  ioctl_dout,
    output logic [23:0]           dip_sw
);
    import m92_pkg::*;

    // Switch bytes as sent by the MRA, active low on the board
    ioctl_byte_t bank [`M92_DIP_BYTES];
    logic        dip_wr;

    assign dip_wr = ioctl_wr && (ioctl_index == `M92_DIP_INDEX)
                    && (ioctl_addr < `M92_DIP_BYTES);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `M92_DIP_BYTES; i++) begin
                bank[i] <= '0;
            end
        end else if (dip_wr) begin
            bank[ioctl_addr[2:0]] <= ioctl_dout;
        end
    end

    // The core only reads the first three bytes
    assign dip_sw = {bank[2], bank[1], bank[0]};

endmodule

// File: hw/m92_glue_top.sv
`timescale 1ns/1ps

module m92_glue_top (
    input  logic                  clk_sys,
    input  logic                  arst_n,

    // Download stream
    input  logic                  ioctl_download,
    input  logic                  ioctl_wr,
    input  m92_pkg::ioctl_index_t ioctl_index,
    input  m92_pkg::sdr_addr_t    ioctl_addr,
    input  m92_pkg::ioctl_byte_t  ioctl_dout,
    output logic                  ioctl_wait,

    // CPU port of channel 3
    input  m92_pkg::sdr_addr_t    cpu_addr,
    input  m92_pkg::sdr_word_t    cpu_din,
    input  m92_pkg::byte_sel_t    cpu_wr_sel,
    input  logic                  cpu_req,
    output logic                  cpu_rdy,
    output m92_pkg::sdr_word_t    cpu_dout,

    // SDRAM channel 3
    output m92_pkg::sdr_addr_t    sdr_ch3_addr,
    output m92_pkg::sdr_word_t    sdr_ch3_din,
    output m92_pkg::byte_sel_t    sdr_ch3_be,
    output logic                  sdr_ch3_rnw,
    output logic                  sdr_ch3_req,
    input  logic                  sdr_ch3_rdy,
    input  m92_pkg::sdr_word_t    sdr_ch3_dout,

    // Player controls
    input  m92_pkg::joy_word_t    joy_p1,
    input  m92_pkg::joy_word_t    joy_p2,
    input  m92_pkg::joy_word_t    joy_p3,
    input  m92_pkg::joy_word_t    joy_p4,
    input  m92_pkg::joy_word_t    key_p1,
    input  m92_pkg::joy_word_t    key_p2,
    input  m92_pkg::joy_word_t    key_p3,
    input  m92_pkg::joy_word_t    key_p4,
    input  logic [3:0]            key_start,
    input  logic [3:0]            key_coin,
    input  logic                  key_pause,
    output m92_pkg::player_bits_t p1_in,
    output m92_pkg::player_bits_t p2_in,
    output m92_pkg::player_bits_t p3_in,
    output m92_pkg::player_bits_t p4_in,
    output logic [3:0]            start_buttons,
    output logic [3:0]            coin,
    output logic                  pause_req,

    output logic [23:0]           dip_sw,

    // Video options
    input  m92_pkg::status_word_t status,
    input  logic                  forced_scandoubler,
    output m92_pkg::ratio_t       arx,
    output m92_pkg::ratio_t       ary,
    output logic [11:0]           crop_size,
    output m92_pkg::crop_off_t    crop_off,
    output logic [1:0]            scale,
    output logic [1:0]            scanline_fx,
    output logic                  scandoubler,
    output m92_pkg::crop_off_t    hoffset_neg,
    output m92_pkg::crop_off_t    voffset_neg
);

    // ROM writer request towards the channel 3 arbiter
    sdram_ch_if rom ();

    rom_word_packer u_packer (.*);

    ch3_arbiter u_arbiter (.*);

    dip_switch_bank u_dip (.*);

    player_input_merge u_inputs (.*);

    video_option_decode u_video (.*);

endmodule

// File: hw/m92_pkg.sv
package m92_pkg;

    ////////////////////////////////////////////////////////////////////
    // SDRAM channel types
    ////////////////////////////////////////////////////////////////////

    // Byte address, bit 0 ignored by the controller
    typedef logic [24:0] sdr_addr_t;
    typedef logic [15:0] sdr_word_t;
    // Bit 1 selects the high byte
    typedef logic [1:0]  byte_sel_t;

    ////////////////////////////////////////////////////////////////////
    // Download and player types
    ////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  ioctl_byte_t;
    typedef logic [7:0]  ioctl_index_t;
    typedef logic [15:0] joy_word_t;
    typedef logic [9:0]  player_bits_t;

    // OSD status word, upper bits are unused here
    typedef logic [31:0] status_word_t;
    typedef logic [11:0] ratio_t;
    typedef logic [4:0]  crop_off_t;

    // ROM word packer states
    typedef enum logic [1:0] {
        PK_IDLE,
        PK_HALF,
        PK_REQ
    } packer_state_t;

    // Channel 3 owner
    typedef enum logic {
        OWN_CPU,
        OWN_ROM
    } ch3_owner_t;

endpackage

// File: hw/player_input_merge.sv
`timescale 1ns/1ps

`include "m92_defs.svh"

module player_input_merge (
    input  m92_pkg::joy_word_t    joy_p1,
    input  m92_pkg::joy_word_t    joy_p2,
    input  m92_pkg::joy_word_t    joy_p3,
    input  m92_pkg::joy_word_t    joy_p4,
    input  m92_pkg::joy_word_t    key_p1,
    input  m92_pkg::joy_word_t    key_p2,
    input  m92_pkg::joy_word_t    key_p3,
    input  m92_pkg::joy_word_t    key_p4,
    input  logic [3:0]            key_start,
    input  logic [3:0]            key_coin,
    input  logic                  key_pause,
    output m92_pkg::player_bits_t p1_in,
    output m92_pkg::player_bits_t p2_in,
    output m92_pkg::player_bits_t p3_in,
    output m92_pkg::player_bits_t p4_in,
    output logic [3:0]            start_buttons,
    output logic [3:0]            coin,
    output logic                  pause_req
);
    import m92_pkg::*;

    joy_word_t merged_p1;
    joy_word_t merged_p2;
    joy_word_t merged_p3;
    joy_word_t merged_p4;
    joy_word_t joy_all;

    ////////////////////////////////////////////////////////////////////
    // Game controls
    ////////////////////////////////////////////////////////////////////

    assign merged_p1 = key_p1 | joy_p1;
    assign merged_p2 = key_p2 | joy_p2;
    assign merged_p3 = key_p3 | joy_p3;
    assign merged_p4 = key_p4 | joy_p4;

    // Directions and buttons sit in the low bits
    assign p1_in = merged_p1[9:0];
    assign p2_in = merged_p2[9:0];
    assign p3_in = merged_p3[9:0];
    assign p4_in = merged_p4[9:0];

    ////////////////////////////////////////////////////////////////////
    // System buttons
    ////////////////////////////////////////////////////////////////////

    // Any pad may coin up, pause or start player 2
    assign joy_all = joy_p1 | joy_p2 | joy_p3 | joy_p4;

    assign start_buttons[0] = joy_p1[`M92_JOY_START] | key_start[0];
    assign start_buttons[1] = joy_p2[`M92_JOY_START] | joy_all[`M92_JOY_START2_ALT]
                              | key_start[1];
    assign start_buttons[2] = joy_p3[`M92_JOY_START] | key_start[2];
    assign start_buttons[3] = joy_p4[`M92_JOY_START] | key_start[3];

    // Single coin slot
    assign coin      = {3'b000, joy_all[`M92_JOY_COIN] | (|key_coin)};
    assign pause_req = joy_all[`M92_JOY_PAUSE] | key_pause;

endmodule

// File: hw/rom_word_packer.sv
`timescale 1ns/1ps

`include "m92_defs.svh"

module rom_word_packer (
    input  logic                 clk_sys,
    input  logic                 arst_n,
    input  logic                 ioctl_download,
    input  logic                 ioctl_wr,
    input  m92_pkg::ioctl_index_t ioctl_index,
    input  m92_pkg::sdr_addr_t   ioctl_addr,
    input  m92_pkg::ioctl_byte_t ioctl_dout,
    sdram_ch_if.requester        rom,
    output logic                 ioctl_wait
);
    import m92_pkg::*;

    packer_state_t state;
    ioctl_byte_t   low_byte;
    sdr_addr_t     word_addr;
    sdr_word_t     word_data;
    logic          rom_wr;
    logic          accept;

    assign rom_wr = ioctl_download && ioctl_wr && (ioctl_index == `M92_ROM_INDEX);
    // No new bytes are taken while a word is waiting for the SDRAM
    assign accept = rom_wr && (state != PK_REQ);

    ////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state <= PK_IDLE;
        end else begin
            case (state)
                PK_IDLE, PK_HALF: begin
                    if (accept) begin
                        state <= ioctl_addr[0] ? PK_REQ : PK_HALF;
                    end else if (!ioctl_download) begin
                        // Drop a dangling low byte at end of download
                        state <= PK_IDLE;
                    end
                end
                PK_REQ: begin
                    if (rom.rdy) begin
                        state <= PK_IDLE;
                    end
                end
                default: state <= PK_IDLE;
            endcase
        end
    end

    // Word assembly
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            if (!ioctl_addr[0]) begin
                low_byte <= ioctl_dout;
            end else begin
                word_addr <= {ioctl_addr[24:1], 1'b0};
                word_data <= {ioctl_dout, low_byte};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////////////

    assign rom.addr = word_addr;
    assign rom.din  = word_data;
    assign rom.be   = 2'b11;
    assign rom.rnw  = 1'b0;
    assign rom.req  = (state == PK_REQ);

    // Stall the download source until the word is written
    assign ioctl_wait = (state == PK_REQ);

endmodule

// File: hw/sdram_ch_if.sv
`timescale 1ns/1ps

interface sdram_ch_if;
    import m92_pkg::*;

    sdr_addr_t addr;
    sdr_word_t din;
    byte_sel_t be;
    logic      rnw;
    logic      req;
    logic      rdy;
    sdr_word_t dout;

    // Side that starts a transaction and holds it until rdy
    modport requester (
        output addr,
        output din,
        output be,
        output rnw,
        output req,
        input  rdy,
        input  dout
    );

    // Side that completes it
    modport server (
        input  addr,
        input  din,
        input  be,
        input  rnw,
        input  req,
        output rdy,
        output dout
    );

endinterface

// File: hw/video_option_decode.sv
`timescale 1ns/1ps

`include "m92_defs.svh"

module video_option_decode (
    input  m92_pkg::status_word_t status,
    input  logic                  forced_scandoubler,
    output m92_pkg::ratio_t       arx,
    output m92_pkg::ratio_t       ary,
    output logic [11:0]           crop_size,
    output m92_pkg::crop_off_t    crop_off,
    output logic [1:0]            scale,
    output logic [1:0]            scanline_fx,
    output logic                  scandoubler,
    output m92_pkg::crop_off_t    hoffset_neg,
    output m92_pkg::crop_off_t    voffset_neg
);
    import m92_pkg::*;

    logic [1:0] ar_code;
    logic       vertical;
    logic       allow_crop;
    crop_off_t  crop_code;

    assign ar_code     = status[2:1];
    assign scanline_fx = status[4:3];
    assign scale       = status[6:5];
    assign vertical    = status[10];
    assign crop_code   = status[16:12];

    // Original aspect follows the monitor orientation
    assign arx = (ar_code == 2'd0) ? (vertical ? 12'd3 : 12'd4) : ratio_t'(ar_code - 2'd1);
    assign ary = (ar_code == 2'd0) ? (vertical ? 12'd4 : 12'd3) : 12'd0;

    // 240p crop needs the native scan rate and normal scale
    assign allow_crop = !forced_scandoubler && (scale == 2'd0);
    assign crop_size  = (allow_crop && status[11]) ? 12'(`M92_CROP_LINES) : 12'd0;

    // Upper codes wrap round to negative offsets
    assign crop_off = (crop_code < `M92_CROP_SPLIT) ? crop_code : crop_code + 5'd15;

    assign scandoubler = forced_scandoubler || (scanline_fx != 2'd0);

    // Sync shift runs opposite to the menu value
    assign hoffset_neg = -status[21:17];
    assign voffset_neg = -status[26:22];

endmodule

// File: include/m92_defs.svh
`ifndef M92_DEFS_SVH
`define M92_DEFS_SVH

// Download targets
`define M92_ROM_INDEX 0
`define M92_DIP_INDEX 254

// DIP switch bank depth in bytes
`define M92_DIP_BYTES 8

// Joystick word bit positions
`define M92_JOY_START      10
`define M92_JOY_COIN       11
`define M92_JOY_START2_ALT 12
`define M92_JOY_PAUSE      13

// 240p crop height
`define M92_CROP_LINES 240
// Crop codes below this are positive offsets
`define M92_CROP_SPLIT 9

`endif

// File: m92_glue.f
+incdir+include
hw/m92_pkg.sv
hw/sdram_ch_if.sv
hw/rom_word_packer.sv
hw/ch3_arbiter.sv
hw/dip_switch_bank.sv
hw/player_input_merge.sv
hw/video_option_decode.sv
hw/m92_glue_top.sv
sim/m92_glue_checker.sv
sim/m92_glue_tb.sv

// File: sim/m92_glue_checker.sv
`timescale 1ns/1ps

module m92_glue_checker (
    input logic                  clk_sys,
    input logic                  arst_n,
    input logic                  ioctl_download,
    input m92_pkg::ioctl_index_t ioctl_index,
    input logic                  ioctl_wait,
    input m92_pkg::sdr_addr_t    sdr_ch3_addr,
    input m92_pkg::sdr_word_t    sdr_ch3_din,
    input m92_pkg::byte_sel_t    sdr_ch3_be,
    input logic                  sdr_ch3_rnw,
    input logic                  sdr_ch3_req,
    input logic                  sdr_ch3_rdy
);

    // Failed assertions so far, summed into the testbench result
    int unsigned fail_count = 0;

    // A pending request keeps req and its fields until rdy
    property req_held;
        @(posedge clk_sys) disable iff (!arst_n)
        (sdr_ch3_req && !sdr_ch3_rdy) |=> (sdr_ch3_req && $stable(sdr_ch3_addr)
            && $stable(sdr_ch3_din) && $stable(sdr_ch3_be) && $stable(sdr_ch3_rnw));
    endproperty

    // Download source is stalled while a ROM word is in flight
    property rom_write_stalls;
        @(posedge clk_sys) disable iff (!arst_n)
        (sdr_ch3_req && ioctl_download && (ioctl_index == 8'd0)) |-> ioctl_wait;
    endproperty

    property reset_quiet;
        @(posedge clk_sys) (!arst_n || $rose(arst_n)) |-> (!sdr_ch3_req && !ioctl_wait);
    endproperty

    a_req_held: assert property (req_held) else begin
        fail_count++;
        $error("channel 3 request dropped or changed before rdy");
    end

    a_rom_write_stalls: assert property (rom_write_stalls) else begin
        fail_count++;
        $error("ROM write request on channel 3 without ioctl_wait");
    end

    a_reset_quiet: assert property (reset_quiet) else begin
        fail_count++;
        $error("request or wait active during or right after reset");
    end

endmodule

// File: sim/m92_glue_tb.sv
`timescale 1ns/1ps

module m92_glue_tb;
    import m92_pkg::*;

    localparam int N_ROM = 4;
    localparam int N_CPU = 4;
    localparam int N_DIP = 7;
    localparam int N_MRG = 5;
    localparam int N_VID = 5;
    // Each SDRAM access costs up to 6 cycles of latency plus handshake overhead
    localparam int TIMEOUT_CYCLES = 3 + (N_ROM + N_CPU) * 12 + (N_DIP + N_MRG + N_VID) * 2 + 50;

    logic         clk_sys = 1'b0;
    logic         arst_n;
    logic         ioctl_download, ioctl_wr, ioctl_wait;
    ioctl_index_t ioctl_index;
    sdr_addr_t    ioctl_addr;
    ioctl_byte_t  ioctl_dout;
    sdr_addr_t    cpu_addr, sdr_ch3_addr;
    sdr_word_t    cpu_din, cpu_dout, sdr_ch3_din;
    sdr_word_t    sdr_ch3_dout = '0;
    byte_sel_t    cpu_wr_sel, sdr_ch3_be;
    logic         cpu_req, cpu_rdy, sdr_ch3_rnw, sdr_ch3_req;
    logic         sdr_ch3_rdy = 1'b0;
    joy_word_t    joy_p1, joy_p2, joy_p3, joy_p4;
    joy_word_t    key_p1, key_p2, key_p3, key_p4;
    logic [3:0]   key_start, key_coin, start_buttons, coin;
    logic         key_pause, pause_req, forced_scandoubler, scandoubler;
    player_bits_t p1_in, p2_in, p3_in, p4_in;
    logic [23:0]  dip_sw;
    status_word_t status;
    ratio_t       arx, ary;
    logic [11:0]  crop_size;
    crop_off_t    crop_off, hoffset_neg, voffset_neg;
    logic [1:0]   scale, scanline_fx;

    // Last access completed by the SDRAM model
    sdr_addr_t    seen_addr;
    sdr_word_t    seen_din;
    byte_sel_t    seen_be;
    logic         seen_rnw;
    int           xact_count = 0;
    int           delay_left = 0;
    int           errors = 0;
    int           cycles = 0;

    //////////////////////////////////////////////////////////////////////
    // Stimulus tables
    //////////////////////////////////////////////////////////////////////

    // ROM pairs: even byte address, low byte, high byte, expected word
    sdr_addr_t    rom_addr [N_ROM] = '{25'h0000000, 25'h0000002, 25'h001fffe, 25'h1000010};
    ioctl_byte_t  rom_lo   [N_ROM] = '{8'h34, 8'hcd, 8'h0f, 8'h5a};
    ioctl_byte_t  rom_hi   [N_ROM] = '{8'h12, 8'hab, 8'hf0, 8'ha5};
    sdr_word_t    rom_word [N_ROM] = '{16'h1234, 16'habcd, 16'hf00f, 16'ha55a};

    sdr_addr_t    cpu_tab_addr [N_CPU] = '{25'h0000100, 25'h0123456, 25'h1abcdef, 25'h0000042};
    sdr_word_t    cpu_tab_din  [N_CPU] = '{16'h0000, 16'hbeef, 16'h00c3, 16'h0000};
    byte_sel_t    cpu_tab_sel  [N_CPU] = '{2'b00, 2'b11, 2'b01, 2'b00};
    logic         cpu_tab_rnw  [N_CPU] = '{1'b1, 1'b0, 1'b0, 1'b1};

    ioctl_index_t dip_idx  [N_DIP] = '{8'd254, 8'd254, 8'd254, 8'd254, 8'd254, 8'd0, 8'd253};
    sdr_addr_t    dip_addr [N_DIP] = '{25'd0, 25'd1, 25'd2, 25'd7, 25'd8, 25'd1, 25'd0};
    ioctl_byte_t  dip_data [N_DIP] = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66, 8'h77};
    logic [23:0]  dip_exp  [N_DIP] = '{24'h000011, 24'h002211, 24'h332211, 24'h332211,
                                       24'h332211, 24'h332211, 24'h332211};

    // System bits are {key_pause, key_coin, key_start} in and {pause_req, coin, start} out
    joy_word_t    mg_joy [N_MRG][4] = '{'{16'h0000, 16'h0000, 16'h0000, 16'h0000},
                                        '{16'h0001, 16'h0002, 16'h0004, 16'h0008},
                                        '{16'h0400, 16'h0000, 16'h1000, 16'h0800},
                                        '{16'h0000, 16'h2000, 16'h0000, 16'h03ff},
                                        '{16'h0000, 16'h0000, 16'h0000, 16'h0000}};
    joy_word_t    mg_key [N_MRG][4] = '{'{16'h0000, 16'h0000, 16'h0000, 16'h0000},
                                        '{16'h0200, 16'h0100, 16'h0000, 16'h0010},
                                        '{16'h0000, 16'hfc00, 16'h0000, 16'h0000},
                                        '{16'h0155, 16'h0000, 16'h02aa, 16'h0000},
                                        '{16'h0000, 16'h0000, 16'h0000, 16'h0000}};
    logic [8:0]   mg_sys [N_MRG] = '{9'h000, 9'h000, 9'h000, 9'h04c, 9'h102};
    player_bits_t mg_exp_in [N_MRG][4] = '{'{10'h000, 10'h000, 10'h000, 10'h000},
                                           '{10'h201, 10'h102, 10'h004, 10'h018},
                                           '{10'h000, 10'h000, 10'h000, 10'h000},
                                           '{10'h155, 10'h000, 10'h2aa, 10'h3ff},
                                           '{10'h000, 10'h000, 10'h000, 10'h000}};
    logic [8:0]   mg_exp_sys [N_MRG] = '{9'h000, 9'h000, 9'h013, 9'h11c, 9'h102};

    status_word_t vd_status [N_VID] = '{32'h0, 32'h00465c00, 32'h0000c80c, 32'h0021f836,
                                        32'h07c08800};
    logic         vd_fsd    [N_VID] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    // {arx, ary, crop_size, crop_off, scale, scanline_fx, scandoubler, hoffset_neg, voffset_neg}
    logic [55:0]  vd_exp [N_VID] = '{
        {12'd4, 12'd3, 12'd0,   5'd0,  2'd0, 2'd0, 1'b0, 5'd0,  5'd0},
        {12'd3, 12'd4, 12'd240, 5'd5,  2'd0, 2'd0, 1'b0, 5'd29, 5'd31},
        {12'd1, 12'd0, 12'd240, 5'd27, 2'd0, 2'd1, 1'b1, 5'd0,  5'd0},
        {12'd2, 12'd0, 12'd0,   5'd14, 2'd1, 2'd2, 1'b1, 5'd16, 5'd0},
        {12'd4, 12'd3, 12'd0,   5'd8,  2'd0, 2'd0, 1'b1, 5'd0,  5'd1}
    };

    m92_glue_top dut (.*);

    bind m92_glue_top m92_glue_checker u_checker (
        .clk_sys, .arst_n, .ioctl_download, .ioctl_index, .ioctl_wait,
        .sdr_ch3_addr, .sdr_ch3_din, .sdr_ch3_be, .sdr_ch3_rnw, .sdr_ch3_req, .sdr_ch3_rdy
    );

    always #10 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // SDRAM model, rdy 1 to 6 cycles after req, read data is the address low half
    initial begin
        void'($urandom(32'hdaa8_f885));
        forever begin
            @(posedge clk_sys or negedge arst_n);
            if (!arst_n) begin
                sdr_ch3_rdy <= 1'b0;
                delay_left = 0;
            end else begin
                sdr_ch3_rdy <= 1'b0;
                if (delay_left == 0 && !sdr_ch3_rdy && sdr_ch3_req) begin
                    delay_left = 1 + ($urandom % 6);
                end
                if (delay_left != 0) begin
                    delay_left = delay_left - 1;
                    if (delay_left == 0) begin
                        sdr_ch3_rdy  <= 1'b1;
                        sdr_ch3_dout <= sdr_ch3_addr[15:0];
                        seen_addr    <= sdr_ch3_addr;
                        seen_din     <= sdr_ch3_din;
                        seen_be      <= sdr_ch3_be;
                        seen_rnw     <= sdr_ch3_rnw;
                        xact_count   <= xact_count + 1;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tasks
    //////////////////////////////////////////////////////////////////////

    task automatic expect_equal(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Even byte then odd byte, then hold off while the word is written
    task automatic write_rom_pair(input sdr_addr_t addr, input ioctl_byte_t lo,
                                  input ioctl_byte_t hi);
        @(negedge clk_sys);
        ioctl_download = 1'b1;
        ioctl_index = 8'd0;
        ioctl_wr = 1'b1;
        ioctl_addr = addr;
        ioctl_dout = lo;
        @(negedge clk_sys);
        ioctl_addr = addr | 25'd1;
        ioctl_dout = hi;
        @(negedge clk_sys);
        ioctl_wr = 1'b0;
        while (ioctl_wait) begin
            @(negedge clk_sys);
        end
    endtask

    task automatic cpu_access(input sdr_addr_t addr, input sdr_word_t din,
                              input byte_sel_t sel, output sdr_word_t rd);
        @(negedge clk_sys);
        cpu_addr = addr;
        cpu_din = din;
        cpu_wr_sel = sel;
        cpu_req = 1'b1;
        @(negedge clk_sys);
        while (!cpu_rdy) begin
            @(negedge clk_sys);
        end
        rd = cpu_dout;
        // req drops in the cycle after rdy
        @(negedge clk_sys);
        cpu_req = 1'b0;
    endtask

    task automatic write_dip_byte(input ioctl_index_t idx, input sdr_addr_t addr,
                                  input ioctl_byte_t data);
        @(negedge clk_sys);
        ioctl_wr = 1'b1;
        ioctl_index = idx;
        ioctl_addr = addr;
        ioctl_dout = data;
        @(negedge clk_sys);
        ioctl_wr = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        sdr_word_t rd_data;

        arst_n = 1'b0;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_index = '0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        cpu_addr = '0;
        cpu_din = '0;
        cpu_wr_sel = '0;
        cpu_req = 1'b0;
        {joy_p1, joy_p2, joy_p3, joy_p4} = '0;
        {key_p1, key_p2, key_p3, key_p4} = '0;
        {key_pause, key_coin, key_start} = '0;
        status = '0;
        forced_scandoubler = 1'b0;
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        arst_n = 1'b1;

        expect_equal("sdr_ch3_req after reset", sdr_ch3_req, 0);
        expect_equal("ioctl_wait after reset", ioctl_wait, 0);
        expect_equal("dip_sw after reset", dip_sw, 0);

        for (int i = 0; i < N_ROM; i++) begin
            write_rom_pair(rom_addr[i], rom_lo[i], rom_hi[i]);
            expect_equal($sformatf("rom pair %0d write count", i), xact_count, i + 1);
            expect_equal($sformatf("rom pair %0d addr", i), seen_addr, rom_addr[i]);
            expect_equal($sformatf("rom pair %0d din", i), seen_din, rom_word[i]);
            expect_equal($sformatf("rom pair %0d be", i), seen_be, 2'b11);
            expect_equal($sformatf("rom pair %0d rnw", i), seen_rnw, 1'b0);
        end
        @(negedge clk_sys);
        ioctl_download = 1'b0;

        for (int i = 0; i < N_CPU; i++) begin
            cpu_access(cpu_tab_addr[i], cpu_tab_din[i], cpu_tab_sel[i], rd_data);
            expect_equal($sformatf("cpu row %0d count", i), xact_count, N_ROM + i + 1);
            expect_equal($sformatf("cpu row %0d addr", i), seen_addr, cpu_tab_addr[i]);
            expect_equal($sformatf("cpu row %0d din", i), seen_din, cpu_tab_din[i]);
            expect_equal($sformatf("cpu row %0d be", i), seen_be, cpu_tab_sel[i]);
            expect_equal($sformatf("cpu row %0d rnw", i), seen_rnw, cpu_tab_rnw[i]);
            expect_equal($sformatf("cpu row %0d dout", i), rd_data, cpu_tab_addr[i][15:0]);
        end

        for (int i = 0; i < N_DIP; i++) begin
            write_dip_byte(dip_idx[i], dip_addr[i], dip_data[i]);
            expect_equal($sformatf("dip row %0d dip_sw", i), dip_sw, dip_exp[i]);
        end

        for (int i = 0; i < N_MRG; i++) begin
            @(negedge clk_sys);
            {joy_p1, joy_p2, joy_p3, joy_p4} = {mg_joy[i][0], mg_joy[i][1],
                                                mg_joy[i][2], mg_joy[i][3]};
            {key_p1, key_p2, key_p3, key_p4} = {mg_key[i][0], mg_key[i][1],
                                                mg_key[i][2], mg_key[i][3]};
            {key_pause, key_coin, key_start} = mg_sys[i];
            @(posedge clk_sys);
            expect_equal($sformatf("merge row %0d p1_in", i), p1_in, mg_exp_in[i][0]);
            expect_equal($sformatf("merge row %0d p2_in", i), p2_in, mg_exp_in[i][1]);
            expect_equal($sformatf("merge row %0d p3_in", i), p3_in, mg_exp_in[i][2]);
            expect_equal($sformatf("merge row %0d p4_in", i), p4_in, mg_exp_in[i][3]);
            expect_equal($sformatf("merge row %0d system bits", i),
                         {pause_req, coin, start_buttons}, mg_exp_sys[i]);
        end

        for (int i = 0; i < N_VID; i++) begin
            @(negedge clk_sys);
            status = vd_status[i];
            forced_scandoubler = vd_fsd[i];
            @(posedge clk_sys);
            expect_equal($sformatf("video row %0d options", i),
                         {arx, ary, crop_size, crop_off, scale, scanline_fx, scandoubler,
                          hoffset_neg, voffset_neg}, vd_exp[i]);
        end

        repeat (2) @(negedge clk_sys);
        $display("Summary: %0d check errors, %0d assertion failures",
                 errors, dut.u_checker.fail_count);
        if (errors == 0 && dut.u_checker.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
